/* verilog.f */
source/rv_pkg.sv
source/decoder.sv
source/register_file.sv
source/control.sv
source/stage_decode.sv
source/id_ex_register.sv
source/decode_top.sv
verif/tb_decode_top.sv

/* verif/tb_decode_top.sv */
`timescale 1ns/1ps

module tb_decode_top import rv_pkg::*; ();

    localparam int cycle_limit = 2000; // Tests need about 700

    logic            clk = 1'b0;
    logic            reset;
    instr_u          instruction;
    logic [xlen-1:0] pc;
    wb_write_t       wr;
    logic            stall;
    logic            flush;
    id_ex_t          id_ex;

    logic [xlen-1:0] reg_model [reg_count]; // Expected register contents
    logic [31:0]     rng_state;
    int              cycles = 0;

    decode_top dut0 (
        .clk         (clk),
        .reset       (reset),
        .instruction (instruction),
        .pc          (pc),
        .wr          (wr),
        .stall       (stall),
        .flush       (flush),
        .id_ex       (id_ex)
    );

    always #4 clk = ~clk;

    task automatic stop_with_failure();
        $display("Something failed");
        $fatal(1, "Run stopped at first error");
    endtask

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= cycle_limit) begin
            $display("Timeout: tests did not finish within %0d cycles", cycle_limit);
            stop_with_failure();
        end
    end

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic [6:0] pick_opcode(input int k);
        case (k)
            0:       return op_reg;
            1:       return op_imm;
            2:       return op_load;
            3:       return op_store;
            4:       return op_branch;
            5:       return op_lui;
            default: return op_jal;
        endcase
    endfunction

    // Fields straight from the RV32I bit positions
    function automatic decoded_t expect_decoded(input logic [31:0] w);
        decoded_t e;
        e.rs1    = w[19:15];
        e.rs2    = w[24:20];
        e.rd     = w[11:7];
        e.funct7 = w[31:25];
        e.funct3 = w[14:12];
        e.opcode = w[6:0];
        e.imm    = '0;
        e.instr_type = instr_bad;
        case (w[6:0])
            op_reg: e.instr_type = instr_r;
            op_imm, op_load: begin
                e.instr_type = instr_i;
                e.imm = {{20{w[31]}}, w[31:20]};
            end
            op_store: begin
                e.instr_type = instr_s;
                e.imm = {{20{w[31]}}, w[31:25], w[11:7]};
            end
            op_branch: begin
                e.instr_type = instr_b;
                e.imm = {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
            end
            op_lui: begin
                e.instr_type = instr_upper;
                e.imm = {w[31:12], 12'b0};
            end
            op_jal: begin
                e.instr_type = instr_j;
                e.imm = {{11{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
            end
            default: e.instr_type = instr_bad;
        endcase
        return e;
    endfunction

    // Rows: {alu_src, alu_op}, {mem_write, mem_read, branch}, {mem_to_reg, reg_write}
    function automatic ctrl_t expect_ctrl(input logic [6:0] op);
        case (op)
            op_reg:    return '{'{1'b0, aluop_rtype},  '{1'b0, 1'b0, 1'b0}, '{1'b0, 1'b1}};
            op_imm:    return '{'{1'b1, aluop_itype},  '{1'b0, 1'b0, 1'b0}, '{1'b0, 1'b1}};
            op_load:   return '{'{1'b1, aluop_add},    '{1'b0, 1'b1, 1'b0}, '{1'b1, 1'b1}};
            op_store:  return '{'{1'b1, aluop_add},    '{1'b1, 1'b0, 1'b0}, '{1'b0, 1'b0}};
            op_branch: return '{'{1'b0, aluop_branch}, '{1'b0, 1'b0, 1'b1}, '{1'b0, 1'b0}};
            op_lui:    return '{'{1'b1, aluop_lui},    '{1'b0, 1'b0, 1'b0}, '{1'b0, 1'b1}};
            op_jal:    return '{'{1'b1, aluop_add},    '{1'b0, 1'b0, 1'b0}, '{1'b0, 1'b1}};
            default:   return '0;
        endcase
    endfunction

    function automatic logic [31:0] make_r(input logic [4:0] rd, input logic [4:0] rs1,
                                           input logic [4:0] rs2);
        return {7'b0, rs2, rs1, 3'b0, rd, op_reg};
    endfunction

    task automatic compare_word(input string name, input logic [xlen-1:0] got,
                                input logic [xlen-1:0] exp);
        if (got !== exp) begin
            $display("Mismatch %s: got %h, expected %h", name, got, exp);
            stop_with_failure();
        end
    endtask

    task automatic compare_decoded(input string name, input decoded_t got, input decoded_t exp);
        if (got !== exp) begin
            $display("Mismatch %s: got %h, expected %h", name, got, exp);
            stop_with_failure();
        end
    endtask

    task automatic compare_ctrl(input string name, input ctrl_t got, input ctrl_t exp);
        if (got !== exp) begin
            $display("Mismatch %s: got %h, expected %h", name, got, exp);
            stop_with_failure();
        end
    endtask

    // Drive one word, let it pass the ID/EX edge, sample mid-cycle
    task automatic apply(input logic [31:0] word, input logic [xlen-1:0] pc_val);
        @(posedge clk);
        instruction <= word;
        pc          <= pc_val;
        @(posedge clk);
        @(negedge clk);
    endtask

    task automatic write_reg(input logic [4:0] rd, input logic [xlen-1:0] data);
        @(posedge clk);
        wr <= '{enable: 1'b1, rd: rd, data: data};
        @(posedge clk);
        wr <= '0;
        if (rd != 5'd0) begin
            reg_model[rd] = data;
        end
    endtask

    task automatic check_outputs(input logic [31:0] word, input logic [xlen-1:0] pc_exp);
        decoded_t dec_exp;
        dec_exp = expect_decoded(word);
        compare_word("id_ex.pc", id_ex.pc, pc_exp);
        compare_word("id_ex.instruction", id_ex.instruction, word);
        compare_decoded("id_ex.dec", id_ex.dec, dec_exp);
        compare_ctrl("id_ex.ctrl", id_ex.ctrl, expect_ctrl(word[6:0]));
        compare_word("id_ex.data_a", id_ex.data_a, reg_model[dec_exp.rs1]);
        compare_word("id_ex.data_b", id_ex.data_b, reg_model[dec_exp.rs2]);
    endtask

    task automatic check_bubble();
        compare_word("id_ex.pc", id_ex.pc, '0);
        compare_word("id_ex.instruction", id_ex.instruction, '0);
        compare_word("id_ex.data_a", id_ex.data_a, '0);
        compare_word("id_ex.data_b", id_ex.data_b, '0);
        compare_decoded("id_ex.dec", id_ex.dec, '0);
        compare_ctrl("id_ex.ctrl", id_ex.ctrl, '0);
    endtask

    task automatic check_reset_state();
        @(negedge clk);
        check_bubble();
        for (int i = 0; i < reg_count; i++) begin
            apply(make_r(5'd1, i[4:0], 5'(31 - i)), 32'h10 + 4 * i);
            check_outputs(make_r(5'd1, i[4:0], 5'(31 - i)), 32'h10 + 4 * i);
        end
    endtask

    task automatic write_and_read_back();
        logic [31:0] word;
        write_reg(5'd3, 32'h1234_5678);
        write_reg(5'd4, 32'h8765_4321);
        write_reg(5'd31, 32'hffff_0001);
        write_reg(5'd0, 32'hdead_beef); // Must be dropped
        apply(make_r(5'd1, 5'd3, 5'd4), 32'h20);
        check_outputs(make_r(5'd1, 5'd3, 5'd4), 32'h20);
        apply(make_r(5'd1, 5'd31, 5'd0), 32'h24);
        check_outputs(make_r(5'd1, 5'd31, 5'd0), 32'h24);
        // Write x3 in the same cycle that reads it
        word = make_r(5'd2, 5'd3, 5'd0);
        @(posedge clk);
        wr          <= '{enable: 1'b1, rd: 5'd3, data: 32'hcafe_f00d};
        instruction <= word;
        pc          <= 32'h40;
        @(posedge clk);
        wr <= '0;
        @(negedge clk);
        check_outputs(word, 32'h40); // Old x3 expected
        reg_model[3] = 32'hcafe_f00d;
        apply(word, 32'h44);
        check_outputs(word, 32'h44);
    endtask

    task automatic decode_format(input logic [31:0] word, input logic [2:0] exp_type,
                                 input logic [xlen-1:0] exp_imm);
        apply(word, 32'h80);
        check_outputs(word, 32'h80);
        compare_word("id_ex.dec.instr_type", id_ex.dec.instr_type, exp_type);
        compare_word("id_ex.dec.imm", id_ex.dec.imm, exp_imm);
    endtask

    task automatic decode_formats();
        decode_format(32'h405201b3, instr_r, 32'h0);          // sub x3, x4, x5
        decode_format(32'hffd30293, instr_i, 32'hffff_fffd);  // addi x5, x6, -3
        decode_format(32'h7ff4a403, instr_i, 32'h0000_07ff);  // lw x8, 2047(x9)
        decode_format(32'hfe712c23, instr_s, 32'hffff_fff8);  // sw x7, -8(x2)
        decode_format(32'hfe2088e3, instr_b, 32'hffff_fff0);  // beq x1, x2, -16
        decode_format(32'habcde537, instr_upper, 32'habcd_e000);
        decode_format(32'hffdff0ef, instr_j, 32'hffff_fffc);  // jal x1, -4
    endtask

    task automatic control_table();
        logic [31:0] word;
        for (int k = 0; k < 9; k++) begin
            rng_state = xorshift(rng_state);
            if (k < 7) begin
                word = {rng_state[31:7], pick_opcode(k)};
            end else begin
                word = {rng_state[31:7], (k == 7) ? 7'b1110011 : 7'b0010111};
            end
            apply(word, 32'h1000 + 4 * k);
            check_outputs(word, 32'h1000 + 4 * k);
        end
        compare_ctrl("id_ex.ctrl", id_ex.ctrl, '0); // Last one unsupported
    endtask

    task automatic stall_and_flush();
        logic [31:0] held;
        logic [31:0] next;
        held = {12'h123, 5'd3, 3'b000, 5'd9, op_imm};
        next = make_r(5'd6, 5'd4, 5'd31);
        apply(held, 32'h100);
        check_outputs(held, 32'h100);
        @(posedge clk);
        stall <= 1'b1;
        for (int k = 0; k < 3; k++) begin
            @(posedge clk);
            instruction <= make_r(5'(k + 1), 5'd3, 5'd4);
            pc          <= 32'h200 + 4 * k;
            @(negedge clk);
            check_outputs(held, 32'h100);
        end
        @(posedge clk);
        flush <= 1'b1; // Stall still high
        @(posedge clk);
        flush       <= 1'b0;
        stall       <= 1'b0;
        instruction <= next;
        pc          <= 32'h300;
        @(negedge clk);
        check_bubble();
        @(posedge clk);
        @(negedge clk);
        check_outputs(next, 32'h300);
    endtask

    task automatic random_words();
        logic [31:0] word;
        logic [31:0] pc_val;
        for (int i = 1; i < reg_count; i++) begin
            rng_state = xorshift(rng_state);
            write_reg(i[4:0], rng_state);
        end
        for (int n = 0; n < 200; n++) begin
            rng_state = xorshift(rng_state);
            word = {rng_state[31:7], pick_opcode(int'(rng_state[2:0]) % 7)};
            rng_state = xorshift(rng_state);
            pc_val = {rng_state[31:2], 2'b00};
            apply(word, pc_val);
            check_outputs(word, pc_val);
        end
    endtask

    initial begin
        reset       = 1'b1;
        instruction = 32'h7ff4a403; // Live load word, only reset can clear id_ex
        pc          = 32'h0000_0ffc;
        wr          = '0;
        stall       = 1'b0;
        flush       = 1'b0;
        rng_state   = 32'hfced4a38;
        for (int i = 0; i < reg_count; i++) begin
            reg_model[i] = '0;
        end
        repeat (16) @(posedge clk);
        reset <= 1'b0;
        check_reset_state();
        write_and_read_back();
        decode_formats();
        control_table();
        stall_and_flush();
        random_words();
        $display("Everything OK");
        $finish;
    end

endmodule

/* source/decode_top.sv */
`timescale 1ns/1ps

module decode_top import rv_pkg::*; (
    input  logic            clk,
    input  logic            reset,
    input  instr_u          instruction,
    input  logic [xlen-1:0] pc,
    input  wb_write_t       wr,
    input  logic            stall,
    input  logic            flush,
    output id_ex_t          id_ex
);

    id_ex_t id; // Combinational decode result

    stage_decode decode0 (
        .clk         (clk),
        .reset       (reset),
        .instruction (instruction),
        .pc          (pc),
        .wr          (wr),
        .id          (id)
    );

    id_ex_register id_ex0 (
        .clk   (clk),
        .reset (reset),
        .stall (stall),
        .flush (flush),
        .d     (id),
        .q     (id_ex)
    );

endmodule

/* source/id_ex_register.sv */
`timescale 1ns/1ps

module id_ex_register import rv_pkg::*; (
    input  logic   clk,
    input  logic   reset,
    input  logic   stall,
    input  logic   flush,
    input  id_ex_t d,
    output id_ex_t q
);

    // Flush wins over stall
    always_ff @(posedge clk) begin
        if (reset || flush) begin
            q <= '0;        // Bubble, all controls inactive
        end else if (!stall) begin
            q <= d;
        end
    end

    // A flushed slot must not carry any control into EX
    a_flush_bubble: assert property (@(posedge clk) flush |=> (q.ctrl == '0))
        else $error("id_ex_register: control left after flush");

    // Stall holds the word when no flush or reset comes along
    a_stall_hold: assert property (@(posedge clk) disable iff (reset)
        (stall && !flush) |=> $stable(q))
        else $error("id_ex_register: word changed during stall");

endmodule

/* source/stage_decode.sv */
`timescale 1ns/1ps

module stage_decode import rv_pkg::*; (
    input  logic            clk,
    input  logic            reset,
    input  instr_u          instruction,
    input  logic [xlen-1:0] pc,
    input  wb_write_t       wr,          // From writeback
    output id_ex_t          id
);

    decoded_t        dec;
    ctrl_t           ctrl;
    logic [xlen-1:0] data_a;
    logic [xlen-1:0] data_b;

    decoder dec0 (
        .instr (instruction),
        .dec   (dec)
    );

    // Source fields address the read ports directly
    register_file rf0 (
        .clk    (clk),
        .reset  (reset),
        .wr     (wr),
        .reg_a  (dec.rs1),
        .reg_b  (dec.rs2),
        .data_a (data_a),
        .data_b (data_b)
    );

    control ctrl0 (
        .instruction (instruction),
        .ctrl        (ctrl)
    );

    // Everything EX needs, in one word
    always_comb begin
        id.pc          = pc;
        id.instruction = instruction;
        id.data_a      = data_a;
        id.data_b      = data_b;
        id.dec         = dec;
        id.ctrl        = ctrl;
    end

endmodule

/* source/control.sv */
`timescale 1ns/1ps

module control import rv_pkg::*; (
    input  instr_u instruction,
    output ctrl_t  ctrl
);

    always_comb begin
        ctrl = '0; // Unknown opcodes leave everything off
        case (instruction.r_fmt.opcode)
            op_reg: begin
                ctrl.ex.alu_op    = aluop_rtype;
                ctrl.wb.reg_write = 1'b1;
            end
            op_imm: begin
                ctrl.ex.alu_src   = 1'b1;
                ctrl.ex.alu_op    = aluop_itype;
                ctrl.wb.reg_write = 1'b1;
            end
            op_load: begin
                ctrl.ex.alu_src    = 1'b1;
                ctrl.ex.alu_op     = aluop_add;  // Address calculation
                ctrl.mem.mem_read  = 1'b1;
                ctrl.wb.mem_to_reg = 1'b1;
                ctrl.wb.reg_write  = 1'b1;
            end
            op_store: begin
                ctrl.ex.alu_src    = 1'b1;
                ctrl.ex.alu_op     = aluop_add;
                ctrl.mem.mem_write = 1'b1;
            end
            op_branch: begin
                ctrl.ex.alu_op  = aluop_branch; // Compares rs1 with rs2
                ctrl.mem.branch = 1'b1;
            end
            op_lui: begin
                ctrl.ex.alu_src   = 1'b1;
                ctrl.ex.alu_op    = aluop_lui;
                ctrl.wb.reg_write = 1'b1;
            end
            op_jal: begin
                ctrl.ex.alu_src   = 1'b1;
                ctrl.ex.alu_op    = aluop_add;
                ctrl.wb.reg_write = 1'b1;   // Link register
            end
            default: begin
                ctrl = '0;
            end
        endcase
    end

    // One memory access per instruction
    always_comb begin
        a_mem_excl: assert final (!(ctrl.mem.mem_read && ctrl.mem.mem_write))
            else $error("control: read and write both set for opcode %h",
                        instruction.r_fmt.opcode);
    end

endmodule

/* source/register_file.sv */
`timescale 1ns/1ps

module register_file import rv_pkg::*; (
    input  logic                  clk,
    input  logic                  reset,
    input  wb_write_t             wr,
    input  logic [reg_addr_w-1:0] reg_a,
    input  logic [reg_addr_w-1:0] reg_b,
    output logic [xlen-1:0]       data_a,
    output logic [xlen-1:0]       data_b
);

    logic [xlen-1:0] regs [reg_count];

    // Single write port from writeback, x0 is never written
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < reg_count; i++) begin
                regs[i] <= '0;
            end
        end else if (wr.enable && (wr.rd != '0)) begin
            regs[wr.rd] <= wr.data;
        end
    end

    // No bypass, a read in the write cycle sees the old value
    assign data_a = regs[reg_a];
    assign data_b = regs[reg_b];

    // x0 relies on reset plus the write guard
    a_x0_zero: assert property (@(posedge clk) disable iff (reset)
        ((reg_a == '0) |-> (data_a == '0)) and ((reg_b == '0) |-> (data_b == '0)))
        else $error("register_file: x0 read back nonzero");

endmodule

/* source/decoder.sv */
`timescale 1ns/1ps

module decoder import rv_pkg::*; (
    input  instr_u   instr,
    output decoded_t dec
);

    logic [2:0]      instr_type;
    logic [xlen-1:0] imm;

    // Format class from the major opcode
    always_comb begin
        case (instr.r_fmt.opcode)
            op_reg:          instr_type = instr_r;
            op_imm, op_load: instr_type = instr_i;
            op_store:        instr_type = instr_s;
            op_branch:       instr_type = instr_b;
            op_lui:          instr_type = instr_upper;
            op_jal:          instr_type = instr_j;
            default:         instr_type = instr_bad;
        endcase
    end

    // Immediate assembly, bit 31 is always the sign
    always_comb begin
        case (instr_type)
            instr_i: begin
                imm = {{(xlen-12){instr.i_fmt.imm[11]}}, instr.i_fmt.imm};
            end
            instr_s: begin
                imm = {{(xlen-12){instr.s_fmt.imm_hi[6]}},
                       instr.s_fmt.imm_hi, instr.s_fmt.imm_lo};
            end
            instr_b: begin
                imm = {{(xlen-12){instr.b_fmt.imm_12}}, instr.b_fmt.imm_11,
                       instr.b_fmt.imm_10_5, instr.b_fmt.imm_4_1, 1'b0};
            end
            instr_upper: begin
                imm = {instr.u_fmt.imm, 12'b0};
            end
            instr_j: begin
                imm = {{(xlen-20){instr.j_fmt.imm_20}}, instr.j_fmt.imm_19_12,
                       instr.j_fmt.imm_11, instr.j_fmt.imm_10_1, 1'b0};
            end
            default: begin
                imm = '0; // R type and bad
            end
        endcase
    end

    // Register and function fields sit at the same bits in every format
    always_comb begin
        dec.rs1        = instr.r_fmt.rs1;
        dec.rs2        = instr.r_fmt.rs2;
        dec.rd         = instr.r_fmt.rd;
        dec.funct7     = instr.r_fmt.funct7;
        dec.funct3     = instr.r_fmt.funct3;
        dec.opcode     = instr.r_fmt.opcode;
        dec.instr_type = instr_type;
        dec.imm        = imm;
    end

    // Supported opcodes always get a real format class
    always_comb begin
        if (instr.r_fmt.opcode inside {op_reg, op_imm, op_load, op_store,
                                       op_branch, op_lui, op_jal}) begin
            a_known_opcode: assert final (dec.instr_type != instr_bad)
                else $error("decoder: supported opcode %h classed as bad",
                            instr.r_fmt.opcode);
        end
    end

endmodule

/* source/rv_pkg.sv */
package rv_pkg;

    localparam int xlen       = 32;
    localparam int reg_count  = 32;
    localparam int reg_addr_w = $clog2(reg_count);

    // RV32I major opcodes
    localparam logic [6:0] op_reg    = 7'b0110011;
    localparam logic [6:0] op_imm    = 7'b0010011;
    localparam logic [6:0] op_load   = 7'b0000011;
    localparam logic [6:0] op_store  = 7'b0100011;
    localparam logic [6:0] op_branch = 7'b1100011;
    localparam logic [6:0] op_lui    = 7'b0110111;
    localparam logic [6:0] op_jal    = 7'b1101111;

    // Format class, zero means unsupported so a bubble reads as bad
    localparam logic [2:0] instr_bad   = 3'd0;
    localparam logic [2:0] instr_r     = 3'd1;
    localparam logic [2:0] instr_i     = 3'd2;
    localparam logic [2:0] instr_s     = 3'd3;
    localparam logic [2:0] instr_b     = 3'd4;
    localparam logic [2:0] instr_upper = 3'd5; // U format
    localparam logic [2:0] instr_j     = 3'd6;

    // Main control ALU class, refined in EX by funct3/funct7
    localparam logic [2:0] aluop_none   = 3'd0;
    localparam logic [2:0] aluop_add    = 3'd1;
    localparam logic [2:0] aluop_branch = 3'd2;
    localparam logic [2:0] aluop_rtype  = 3'd3;
    localparam logic [2:0] aluop_itype  = 3'd4;
    localparam logic [2:0] aluop_lui    = 3'd5;

    typedef struct packed {
        logic [6:0]            funct7;
        logic [reg_addr_w-1:0] rs2;
        logic [reg_addr_w-1:0] rs1;
        logic [2:0]            funct3;
        logic [reg_addr_w-1:0] rd;
        logic [6:0]            opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [11:0]           imm;
        logic [reg_addr_w-1:0] rs1;
        logic [2:0]            funct3;
        logic [reg_addr_w-1:0] rd;
        logic [6:0]            opcode;
    } i_fmt_t;

    typedef struct packed {
        logic [6:0]            imm_hi; // imm[11:5]
        logic [reg_addr_w-1:0] rs2;
        logic [reg_addr_w-1:0] rs1;
        logic [2:0]            funct3;
        logic [4:0]            imm_lo; // imm[4:0]
        logic [6:0]            opcode;
    } s_fmt_t;

    typedef struct packed {
        logic                  imm_12;
        logic [5:0]            imm_10_5;
        logic [reg_addr_w-1:0] rs2;
        logic [reg_addr_w-1:0] rs1;
        logic [2:0]            funct3;
        logic [3:0]            imm_4_1;
        logic                  imm_11;
        logic [6:0]            opcode;
    } b_fmt_t;

    typedef struct packed {
        logic [19:0]           imm; // imm[31:12]
        logic [reg_addr_w-1:0] rd;
        logic [6:0]            opcode;
    } u_fmt_t;

    typedef struct packed {
        logic                  imm_20;
        logic [9:0]            imm_10_1;
        logic                  imm_11;
        logic [7:0]            imm_19_12;
        logic [reg_addr_w-1:0] rd;
        logic [6:0]            opcode;
    } j_fmt_t;

    // One fetched word, viewed per format
    typedef union packed {
        r_fmt_t r_fmt;
        i_fmt_t i_fmt;
        s_fmt_t s_fmt;
        b_fmt_t b_fmt;
        u_fmt_t u_fmt;
        j_fmt_t j_fmt;
    } instr_u;

    typedef struct packed {
        logic [reg_addr_w-1:0] rs1;
        logic [reg_addr_w-1:0] rs2;
        logic [reg_addr_w-1:0] rd;
        logic [6:0]            funct7;
        logic [2:0]            funct3;
        logic [6:0]            opcode;
        logic [2:0]            instr_type;
        logic [xlen-1:0]       imm;
    } decoded_t;

    typedef struct packed {
        logic       alu_src; // 1 selects the immediate
        logic [2:0] alu_op;
    } ex_ctrl_t;

    typedef struct packed {
        logic mem_write;
        logic mem_read;
        logic branch;
    } mem_ctrl_t;

    typedef struct packed {
        logic mem_to_reg;
        logic reg_write;
    } wb_ctrl_t;

    typedef struct packed {
        ex_ctrl_t  ex;
        mem_ctrl_t mem;
        wb_ctrl_t  wb;
    } ctrl_t;

    typedef struct packed {
        logic                  enable;
        logic [reg_addr_w-1:0] rd;
        logic [xlen-1:0]       data;
    } wb_write_t;

    typedef struct packed {
        logic [xlen-1:0] pc;
        instr_u          instruction;
        logic [xlen-1:0] data_a;
        logic [xlen-1:0] data_b;
        decoded_t        dec;
        ctrl_t           ctrl;
    } id_ex_t;

endpackage
